//--- conv_pkg.sv
`default_nettype none

package conv_pkg;

    // operand widths of one input beat
    parameter int ACT_W = 12;
    parameter int WGT_W = 8;
    parameter int TAPS = 9;

    // a 12x8 signed product fits in 20 bits
    parameter int PROD_W = 20;

    // nine products over several channels plus the shifted bias
    parameter int SUM_W = 26;

    parameter int OUT_W = 12;

    // the bias enters the accumulator at the same scale as the products
    parameter int BIAS_SHIFT = 8;

    // half of the weight of the lowest kept bit, added once per result
    parameter int ROUND_CONST = 64;

    // the result is accumulator bits SIGN_BIT down to FRAC_SHIFT
    parameter int FRAC_SHIFT = 7;
    parameter int SIGN_BIT = 18;

    parameter int DEF_CH_NUM = 4;
    parameter int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- tap_multiplier.sv
`default_nettype none

// tap i of each vector sits at bits [i*W +: W]
module tap_multiplier (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            in_valid,
    input  logic [conv_pkg::TAPS*conv_pkg::ACT_W-1:0]       act_window,
    input  logic [conv_pkg::TAPS*conv_pkg::WGT_W-1:0]       weights,
    input  logic [conv_pkg::WGT_W-1:0]                      bias,
    output logic                                            prod_valid,
    output logic [conv_pkg::TAPS*conv_pkg::PROD_W-1:0]      products,
    output logic [conv_pkg::WGT_W-1:0]                      bias_q
);

    for (genvar i = 0; i < conv_pkg::TAPS; i++) begin : g_tap
        logic signed [conv_pkg::PROD_W-1:0] act_ext;
        logic signed [conv_pkg::PROD_W-1:0] wgt_ext;

        assign act_ext = {{(conv_pkg::PROD_W - conv_pkg::ACT_W)
                           {act_window[i*conv_pkg::ACT_W + conv_pkg::ACT_W - 1]}},
                          act_window[i*conv_pkg::ACT_W +: conv_pkg::ACT_W]};
        assign wgt_ext = {{(conv_pkg::PROD_W - conv_pkg::WGT_W)
                           {weights[i*conv_pkg::WGT_W + conv_pkg::WGT_W - 1]}},
                          weights[i*conv_pkg::WGT_W +: conv_pkg::WGT_W]};

        // both operands are already PROD_W wide, so the low bits are exact
        always_ff @(posedge clk) begin
            products[i*conv_pkg::PROD_W +: conv_pkg::PROD_W] <= act_ext * wgt_ext;
        end
    end

    always_ff @(posedge clk) begin
        bias_q <= bias;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

//--- window_adder.sv
`default_nettype none

module window_adder (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            prod_valid,
    input  logic [conv_pkg::TAPS*conv_pkg::PROD_W-1:0]      products,
    input  logic [conv_pkg::WGT_W-1:0]                      bias_q,
    output logic                                            sum_valid,
    output logic [conv_pkg::SUM_W-1:0]                      window_sum,
    output logic [conv_pkg::WGT_W-1:0]                      bias_qq
);

    logic [conv_pkg::SUM_W-1:0] sum_comb;

    // every product is widened with its own sign before the add
    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < conv_pkg::TAPS; i++) begin
            sum_comb = sum_comb
                     + {{(conv_pkg::SUM_W - conv_pkg::PROD_W)
                         {products[i*conv_pkg::PROD_W + conv_pkg::PROD_W - 1]}},
                        products[i*conv_pkg::PROD_W +: conv_pkg::PROD_W]};
        end
    end

    always_ff @(posedge clk) begin
        window_sum <= sum_comb;
        bias_qq <= bias_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid;
        end
    end

endmodule

`default_nettype wire

//--- channel_accumulator.sv
`default_nettype none

module channel_accumulator #(
    parameter int CH_NUM = conv_pkg::DEF_CH_NUM
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sum_valid,
    input  logic [conv_pkg::SUM_W-1:0]      window_sum,
    input  logic [conv_pkg::WGT_W-1:0]      bias_qq,
    output logic                            acc_valid,
    output logic [conv_pkg::SUM_W-1:0]      acc_value
);

    // wide enough to hold CH_NUM itself so an overrun can show up
    localparam int CNT_W = $clog2(CH_NUM + 1);

    logic [CNT_W-1:0]           ch_cnt;
    logic                       last_beat;
    logic [conv_pkg::SUM_W-1:0] bias_term;

    assign last_beat = (ch_cnt == CNT_W'(CH_NUM - 1));

    // signed bias moved up to product scale, plus the rounding constant
    assign bias_term = ({{(conv_pkg::SUM_W - conv_pkg::WGT_W){bias_qq[conv_pkg::WGT_W-1]}},
                         bias_qq} << conv_pkg::BIAS_SHIFT)
                     + conv_pkg::SUM_W'(conv_pkg::ROUND_CONST);

    // the first beat of a group overwrites whatever the last group left behind
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            if (ch_cnt == '0) begin
                acc_value <= window_sum + bias_term;
            end else begin
                acc_value <= acc_value + window_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ch_cnt <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= sum_valid && last_beat;
            if (sum_valid) begin
                if (last_beat) begin
                    ch_cnt <= '0;
                end else begin
                    ch_cnt <= ch_cnt + 1'b1;
                end
            end
        end
    end

    a_ch_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        ch_cnt < CNT_W'(CH_NUM)
    );

endmodule

`default_nettype wire

//--- result_buffer.sv
`default_nettype none

module result_buffer #(
    parameter int FIFO_DEPTH = conv_pkg::DEF_FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            acc_valid,
    input  logic [conv_pkg::SUM_W-1:0]      acc_value,
    input  logic                            out_credit,
    output logic                            out_valid,
    output logic [conv_pkg::OUT_W-1:0]      out_data,
    output logic                            in_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    // the consumer may grant well ahead of the results
    localparam int CRED_W = 16;

    logic [conv_pkg::OUT_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           fill;
    logic [CRED_W-1:0]          credit_cnt;
    logic [conv_pkg::OUT_W-1:0] quant;
    logic                       push;
    logic                       pop;

    // negative sums clamp to zero, otherwise keep the middle bits as they are
    assign quant = acc_value[conv_pkg::SIGN_BIT] ? '0
                 : acc_value[conv_pkg::SIGN_BIT:conv_pkg::FRAC_SHIFT];

    assign push = acc_valid;
    assign pop = (fill != '0) && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= quant;
        end
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            credit_cnt <= '0;
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            out_valid <= pop;
            // the slot is handed back to the producer one cycle after delivery
            in_credit <= out_valid;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_valid |-> fill < CNT_W'(FIFO_DEPTH)
    );

    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(credit_cnt) != '0
    );

endmodule

`default_nettype wire

//--- conv_core.sv
`default_nettype none

module conv_core #(
    parameter int CH_NUM = conv_pkg::DEF_CH_NUM,
    parameter int FIFO_DEPTH = conv_pkg::DEF_FIFO_DEPTH
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            in_valid,
    input  logic [conv_pkg::TAPS*conv_pkg::ACT_W-1:0]       act_window,
    input  logic [conv_pkg::TAPS*conv_pkg::WGT_W-1:0]       weights,
    input  logic [conv_pkg::WGT_W-1:0]                      bias,
    input  logic                                            out_credit,
    output logic                                            in_credit,
    output logic                                            out_valid,
    output logic [conv_pkg::OUT_W-1:0]                      out_data
);

    logic                                       prod_valid;
    logic [conv_pkg::TAPS*conv_pkg::PROD_W-1:0] products;
    logic [conv_pkg::WGT_W-1:0]                 bias_q;
    logic                                       sum_valid;
    logic [conv_pkg::SUM_W-1:0]                 window_sum;
    logic [conv_pkg::WGT_W-1:0]                 bias_qq;
    logic                                       acc_valid;
    logic [conv_pkg::SUM_W-1:0]                 acc_value;

    tap_multiplier tap_multiplier_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .act_window (act_window),
        .weights    (weights),
        .bias       (bias),
        .prod_valid (prod_valid),
        .products   (products),
        .bias_q     (bias_q)
    );

    window_adder window_adder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_valid (prod_valid),
        .products   (products),
        .bias_q     (bias_q),
        .sum_valid  (sum_valid),
        .window_sum (window_sum),
        .bias_qq    (bias_qq)
    );

    channel_accumulator #(
        .CH_NUM (CH_NUM)
    ) channel_accumulator_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_valid  (sum_valid),
        .window_sum (window_sum),
        .bias_qq    (bias_qq),
        .acc_valid  (acc_valid),
        .acc_value  (acc_value)
    );

    // there is no stall upstream, the FIFO must absorb every finished group
    result_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) result_buffer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_valid  (acc_valid),
        .acc_value  (acc_value),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

//--- conv_checker.sv
`default_nettype none

// reference model of the core, fed only from what crosses the DUT ports
module conv_checker #(
    parameter int CH_NUM = conv_pkg::DEF_CH_NUM
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            in_valid,
    input  logic [conv_pkg::TAPS*conv_pkg::ACT_W-1:0]       act_window,
    input  logic [conv_pkg::TAPS*conv_pkg::WGT_W-1:0]       weights,
    input  logic [conv_pkg::WGT_W-1:0]                      bias,
    input  logic                                            in_credit,
    input  logic                                            out_valid,
    input  logic [conv_pkg::OUT_W-1:0]                      out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int expected_q[$];
    int beat_cnt = 0;
    int acc_model = 0;
    int pending = 0;
    int mismatches = 0;
    int results_checked = 0;
    int in_credit_cnt = 0;
    int out_valid_cnt = 0;

    // signed dot product of the current window and kernel
    function automatic int window_sum();
        int sum;
        logic signed [conv_pkg::ACT_W-1:0] a;
        logic signed [conv_pkg::WGT_W-1:0] w;
        sum = 0;
        for (int i = 0; i < conv_pkg::TAPS; i++) begin
            a = act_window[i*conv_pkg::ACT_W +: conv_pkg::ACT_W];
            w = weights[i*conv_pkg::WGT_W +: conv_pkg::WGT_W];
            sum += int'(a) * int'(w);
        end
        return sum;
    endfunction

    always @(posedge clk) begin : model
        int expected;
        if (!rst_n) begin
            expected_q.delete();
            beat_cnt = 0;
        end else begin
            if (in_valid) begin
                // bias and rounding enter once, with the first channel
                if (beat_cnt == 0) begin
                    acc_model = window_sum() + int'($signed(bias)) * (1 << conv_pkg::BIAS_SHIFT)
                              + conv_pkg::ROUND_CONST;
                end else begin
                    acc_model += window_sum();
                end
                beat_cnt++;
                if (beat_cnt == CH_NUM) begin
                    // negative sums give 0, otherwise bits 18 down to 7 untouched
                    expected = acc_model[conv_pkg::SIGN_BIT] ? 0
                             : int'(acc_model[conv_pkg::SIGN_BIT:conv_pkg::FRAC_SHIFT]);
                    expected_q.push_back(expected);
                    beat_cnt = 0;
                end
            end
            in_credit_cnt += int'(in_credit);
            if (out_valid) begin
                out_valid_cnt++;
                if (expected_q.size() == 0) begin
                    mismatches++;
                    $display("out_valid at %0t while no result was expected", $time);
                end else begin
                    expected = expected_q.pop_front();
                    results_checked++;
                    if (int'(out_data) != expected) begin
                        mismatches++;
                        $display("[FAIL] %0t out_data expected %0d actual %0d",
                                 $time, expected, out_data);
                    end
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

`default_nettype wire

//--- tb_conv_core.sv
`default_nettype none

module tb_conv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CH_NUM = conv_pkg::DEF_CH_NUM;
    localparam int FIFO_DEPTH = conv_pkg::DEF_FIFO_DEPTH;
    localparam int ACT_W = conv_pkg::ACT_W;
    localparam int WGT_W = conv_pkg::WGT_W;
    localparam int TIMEOUT = 200;
    localparam int RANDOM_GROUPS = 200;
    localparam int HOLD_CYCLES = 100;
    localparam int WAIT_CREDIT = 0;
    localparam int WAIT_RESULT = 1;
    localparam int WAIT_DRAIN = 2;

    logic                               clk;
    logic                               rst_n;
    logic                               in_valid;
    logic [conv_pkg::TAPS*ACT_W-1:0]    act_window;
    logic [conv_pkg::TAPS*WGT_W-1:0]    weights;
    logic [WGT_W-1:0]                   bias;
    logic                               out_credit;
    logic                               in_credit;
    logic                               out_valid;
    logic [conv_pkg::OUT_W-1:0]         out_data;

    int beat_credits = 0;
    // 0 withholds out_credit, 1 grants at random, 2 grants every cycle
    int grant_mode = 2;
    bit timed_out = 1'b0;
    int errors = 0;
    int tests_run = 0;
    int err_mark = 0;

    conv_core #(.CH_NUM(CH_NUM), .FIFO_DEPTH(FIFO_DEPTH)) conv_core_inst (.*);

    conv_checker #(.CH_NUM(CH_NUM)) conv_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // producer credits are spent per accepted beat and restored per in_credit pulse
    always @(posedge clk) begin
        if (!rst_n) begin
            beat_credits <= FIFO_DEPTH * CH_NUM;
        end else begin
            beat_credits <= beat_credits - int'(in_valid) + (in_credit ? CH_NUM : 0);
        end
    end

    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            case (grant_mode)
                0:       out_credit = 1'b0;
                1:       out_credit = ($urandom % 2) == 1;
                default: out_credit = 1'b1;
            endcase
        end
    end

    function automatic void check_value(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endfunction

    task automatic report_test(input string name);
        int total;
        total = errors + conv_checker_inst.mismatches;
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (total == err_mark && !timed_out) ? "ok" : "failed");
        err_mark = total;
    endtask

    function automatic bit ready(input int what);
        case (what)
            WAIT_CREDIT: return beat_credits > 0;
            WAIT_RESULT: return out_valid;
            default:     return conv_checker_inst.pending == 0;
        endcase
    endfunction

    task automatic wait_for(input int what, input string label, output int cycles);
        cycles = 0;
        while (!ready(what) && !timed_out) begin
            if (cycles == TIMEOUT) begin
                $display("timeout after %0d cycles waiting for %s", TIMEOUT, label);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // every tap gets the same fixed value unless random_data is set
    task automatic send_beat(input bit random_data, input int act_val, input int wgt_val,
                             input int bias_val);
        int waited;
        wait_for(WAIT_CREDIT, "beat credit", waited);
        if (!timed_out) begin
            for (int i = 0; i < conv_pkg::TAPS; i++) begin
                act_window[i*ACT_W +: ACT_W] = random_data ? ACT_W'($urandom) : ACT_W'(act_val);
                weights[i*WGT_W +: WGT_W] = random_data ? WGT_W'($urandom) : WGT_W'(wgt_val);
            end
            bias = random_data ? WGT_W'($urandom) : WGT_W'(bias_val);
            in_valid = 1'b1;
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    initial begin
        int cycles;
        int beats;
        int ov_mark;
        int ic_mark;
        int total;
        void'($urandom(81));
        rst_n = 1'b0;
        in_valid = 1'b0;
        act_window = '0;
        weights = '0;
        bias = '0;
        reset_dut();

        // credits keep arriving but there is nothing to deliver
        for (int i = 0; i < 10; i++) begin
            check_value("out_valid", 0, int'(out_valid));
            check_value("in_credit", 0, int'(in_credit));
            @(posedge clk);
            #2;
        end
        report_test("idle after reset");
        grant_mode = 1;

        for (int i = 0; i < CH_NUM; i++) begin
            send_beat(1'b0, 3, 2, 1);
        end
        wait_for(WAIT_RESULT, "out_valid", cycles);
        check_value("out_valid latency", 4, cycles);
        wait_for(WAIT_DRAIN, "expected results", cycles);
        report_test("single group");

        // large activations against negative weights and bias
        for (int i = 0; i < CH_NUM; i++) begin
            send_beat(1'b0, 100, -5, -10);
        end
        wait_for(WAIT_RESULT, "out_valid", cycles);
        check_value("out_data", 0, int'(out_data));
        wait_for(WAIT_DRAIN, "expected results", cycles);
        report_test("negative group");

        for (int i = 0; i < RANDOM_GROUPS * CH_NUM; i++) begin
            send_beat(1'b1, 0, 0, 0);
        end
        wait_for(WAIT_DRAIN, "expected results", cycles);
        report_test("random groups");

        // with no output credit the producer has to run dry
        grant_mode = 0;
        reset_dut();
        ov_mark = conv_checker_inst.out_valid_cnt;
        ic_mark = conv_checker_inst.in_credit_cnt;
        beats = 0;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            if (beat_credits > 0) begin
                send_beat(1'b1, 0, 0, 0);
                beats++;
            end else begin
                @(posedge clk);
                #2;
            end
        end
        check_value("beats accepted", FIFO_DEPTH * CH_NUM, beats);
        check_value("out_valid while held", 0, conv_checker_inst.out_valid_cnt - ov_mark);
        grant_mode = 1;
        wait_for(WAIT_DRAIN, "held results", cycles);
        // the last in_credit trails its result by one cycle
        repeat (2) @(posedge clk);
        #2;
        check_value("results delivered", FIFO_DEPTH, conv_checker_inst.out_valid_cnt - ov_mark);
        check_value("in_credit pulses", conv_checker_inst.out_valid_cnt - ov_mark,
                    conv_checker_inst.in_credit_cnt - ic_mark);
        report_test("back-pressure");

        total = errors + conv_checker_inst.mismatches;
        $display("tests run: %0d, failed checks: %0d, results compared: %0d",
                 tests_run, total, conv_checker_inst.results_checked);
        if (total == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
conv_pkg.sv
tap_multiplier.sv
window_adder.sv
channel_accumulator.sv
result_buffer.sv
conv_core.sv
conv_checker.sv
tb_conv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_conv_core
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
